/* Makefile */
VERILATOR ?= verilator
TOP ?= sprite_engine_tb
FILELIST ?= sprite_engine.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= ALL CHECKS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BINARY))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/sprite_engine_tb.sv */
`default_nettype none

module sprite_engine_tb;
	import sprite_pkg::*;

	localparam int line_total = 20;
	localparam int line_cycles = 9000;
	localparam int clk_period = 20;
	localparam int watchdog_time = (line_total * line_cycles + 2000) * clk_period;

	logic clk;
	logic reset;
	logic hsync;
	logic [pos_w-1:0] vcnt;
	logic [pos_w-1:0] hcnt;
	logic [spr_ram_addr_w-1:0] spr_ram_addr;
	logic [7:0] spr_ram_data = '0;
	logic [rom_addr_w-1:0] rom_addr;
	logic [7:0] rom_data = '0;
	logic [pal_addr_w-1:0] pal_addr;
	logic [pal_word_w-1:0] pal_data = '0;
	logic [7:0] spr_r;
	logic [7:0] spr_g;
	logic [7:0] spr_b;
	logic spr_a;

	// Memory contents
	logic [7:0] spr_ram [0:127];
	logic [7:0] rom [0:16383];
	logic [pal_word_w-1:0] pal_rom [0:255];
	logic [rom_addr_w-1:0] offset [0:2];

	// Expected lines indexed like the line buffer
	logic [pal_word_w-1:0] pending_line [0:511];
	logic [pal_word_w-1:0] shown_line [0:511];
	logic [pal_word_w-1:0] exp_word;

	logic check_on;
	logic shown_valid;
	logic check_q = 1'b0;
	logic [pos_w-1:0] hcnt_q;
	logic [7:0] exp_r;
	logic [7:0] exp_g;
	logic [7:0] exp_b;
	logic exp_a;
	int checks = 0;
	int errors = 0;
	logic [31:0] lfsr = 32'h3349;

	sprite_engine DUT (
		.clk(clk),
		.reset(reset),
		.hsync(hsync),
		.vcnt(vcnt),
		.hcnt(hcnt),
		.spr_ram_addr(spr_ram_addr),
		.spr_ram_data(spr_ram_data),
		.rom_addr(rom_addr),
		.rom_data(rom_data),
		.pal_addr(pal_addr),
		.pal_data(pal_data),
		.spr_r(spr_r),
		.spr_g(spr_g),
		.spr_b(spr_b),
		.spr_a(spr_a)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// Synchronous reads with one cycle of latency
	always @(posedge clk)
	begin
		spr_ram_data <= spr_ram[spr_ram_addr];
		rom_data <= rom[rom_addr];
		pal_data <= pal_rom[pal_addr];
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
	endfunction

	function int random_bits(input int n);
		int v;
		int k;
		v = 0;
		for (k = 0; k < n; k++)
		begin
			lfsr = lfsr_next(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
		return v;
	endfunction

	// Top bits repeated below a 5-bit channel
	function automatic logic [7:0] widen_channel(input logic [4:0] c);
		widen_channel = {c, c[4:2]};
	endfunction

	function automatic int span_of(input logic [1:0] code);
		case (code)
			2'd0: span_of = 31;
			2'd1: span_of = 15;
			2'd2: span_of = 7;
			default: span_of = 0;
		endcase
	endfunction

	assign exp_word = shown_line[hcnt + border];

	// Expected pixel follows hcnt by one clock like the DUT read
	always @(posedge clk)
	begin
		check_q <= check_on;
		hcnt_q <= hcnt;
		exp_r <= widen_channel(exp_word[4:0]);
		exp_g <= widen_channel(exp_word[9:5]);
		exp_b <= widen_channel(exp_word[14:10]);
		exp_a <= exp_word[15];
		if (check_q)
			checks <= checks + 1;
	end

	task automatic log_pixel_error(input string name, input logic [pos_w-1:0] h,
		input logic [7:0] got, input logic [7:0] want);
		errors++;
		$display("Mismatch %s at hcnt %0d: got %h, expected %h", name, h, got, want);
	endtask

	red_match: assert property (@(posedge clk) check_q |-> spr_r == exp_r)
		else log_pixel_error("spr_r", $sampled(hcnt_q), $sampled(spr_r), $sampled(exp_r));
	green_match: assert property (@(posedge clk) check_q |-> spr_g == exp_g)
		else log_pixel_error("spr_g", $sampled(hcnt_q), $sampled(spr_g), $sampled(exp_g));
	blue_match: assert property (@(posedge clk) check_q |-> spr_b == exp_b)
		else log_pixel_error("spr_b", $sampled(hcnt_q), $sampled(spr_b), $sampled(exp_b));
	alpha_match: assert property (@(posedge clk) check_q |-> spr_a == exp_a)
		else log_pixel_error("spr_a", $sampled(hcnt_q), 8'($sampled(spr_a)),
			8'($sampled(exp_a)));

	task automatic fill_memories();
		int a;
		for (a = 0; a < 16384; a++)
			rom[14'(a)] = 8'(random_bits(8));
		for (a = 0; a < 256; a++)
			pal_rom[8'(a)] = 16'(random_bits(16));
		// High bytes of the offset table carry top bits that the DUT drops
		rom[0] = 8'hC0;
		rom[1] = 8'h40;
		rom[2] = 8'h90;
		rom[3] = 8'h00;
		rom[4] = 8'h3C;
		rom[5] = 8'h80;
		for (a = 0; a < 3; a++)
			offset[2'(a)] = {rom[14'(2 * a)][5:0], rom[14'(2 * a + 1)]};
	endtask

	task automatic clear_sprites();
		int a;
		for (a = 0; a < 128; a++)
			spr_ram[7'(a)] = 8'h00;
	endtask

	task automatic set_sprite(input int idx, input logic en, input logic [1:0] pal,
		input logic [1:0] size, input logic [5:0] image, input logic [8:0] x,
		input logic [8:0] y);
		sprite_ctrl_u c0;
		sprite_ctrl_u c2;
		c0 = '0;
		c0.y_view.enable = en;
		c0.y_view.palette = pal;
		c0.y_view.size = size;
		c0.y_view.y_hi = y[8];
		c2 = '0;
		c2.x_view.image = image;
		c2.x_view.x_hi = x[8];
		spr_ram[7'(desc_bytes * idx)] = c0;
		spr_ram[7'(desc_bytes * idx + 1)] = y[7:0];
		spr_ram[7'(desc_bytes * idx + 2)] = c2;
		spr_ram[7'(desc_bytes * idx + 3)] = x[7:0];
	endtask

	task automatic render_reference(input logic [pos_w-1:0] v);
		sprite_ctrl_u c0;
		sprite_ctrl_u c2;
		logic [7:0] pix;
		logic [pal_word_w-1:0] word;
		int ay;
		int y;
		int x;
		int span;
		int row;
		int image;
		int base;
		int i;
		int p;
		int a;
		for (a = 0; a < 512; a++)
			pending_line[9'(a)] = '0;
		ay = (v == 9'd255) ? 32 : (int'(v) + 33) % 512;
		for (i = 0; i < sprite_count; i++)
		begin
			c0 = spr_ram[7'(desc_bytes * i)];
			y = int'({c0.y_view.y_hi, spr_ram[7'(desc_bytes * i + 1)]});
			span = span_of(c0.y_view.size);
			if (c0.y_view.enable && y <= ay && ay <= y + span)
			begin
				c2 = spr_ram[7'(desc_bytes * i + 2)];
				x = int'({c2.x_view.x_hi, spr_ram[7'(desc_bytes * i + 3)]});
				image = int'(c2.x_view.image);
				row = ay - y;
				case (c0.y_view.size)
					2'd0: base = int'(offset[0]) + (image % 16) * 1024 + row * 32;
					2'd1: base = int'(offset[1]) + image * 256 + row * 16;
					default: base = int'(offset[2]) + image * 64 + row * 8;
				endcase
				for (p = 0; p <= span; p++)
				begin
					pix = rom[14'(base + p)];
					word = pal_rom[{c0.y_view.palette, pix[4:0], 1'b0}];
					// Later sprites overwrite and clear alpha leaves the pixel alone
					if (word[15])
						pending_line[9'(x + p)] = word;
				end
			end
		end
	endtask

	// One hsync period starts a render and shows the previous line
	task automatic run_line(input logic [pos_w-1:0] v);
		int h;
		int a;
		@(negedge clk);
		for (a = 0; a < 512; a++)
			shown_line[9'(a)] = pending_line[9'(a)];
		render_reference(v);
		vcnt = v;
		hsync = 1'b1;
		for (h = 0; h < 320; h++)
		begin
			@(negedge clk);
			hcnt = 9'(h);
			check_on = shown_valid;
			if (h == 4)
				hsync = 1'b0;
		end
		@(negedge clk);
		check_on = 1'b0;
		hcnt = '0;
		repeat (line_cycles - 322) @(negedge clk);
		shown_valid = 1'b1;
	endtask

	initial
	begin
		logic [pos_w-1:0] v;
		int ay;
		int n;
		int i;
		reset = 1'b1;
		hsync = 1'b0;
		vcnt = '0;
		hcnt = '0;
		check_on = 1'b0;
		shown_valid = 1'b0;
		fill_memories();
		clear_sprites();
		repeat (16) @(negedge clk);
		reset = 1'b0;
		// Room for the offset table load
		repeat (40) @(negedge clk);

		run_line(9'd10);
		run_line(9'd11);

		// One sprite per size code where image 53 also exercises the 32x32 image bits
		set_sprite(0, 1'b1, 2'd0, 2'd0, 6'd53, 9'd40, 9'd60);
		set_sprite(1, 1'b1, 2'd1, 2'd1, 6'd37, 9'd100, 9'd60);
		set_sprite(2, 1'b1, 2'd2, 2'd2, 6'd50, 9'd200, 9'd60);
		set_sprite(3, 1'b1, 2'd3, 2'd3, 6'd63, 9'd260, 9'd60);
		set_sprite(4, 1'b1, 2'd3, 2'd2, 6'd12, 9'd150, 9'd32);
		// Lines at the Y range edges starting with the vcnt 255 rule
		run_line(9'd255);
		run_line(9'd26);
		run_line(9'd27);
		run_line(9'd34);
		run_line(9'd35);
		run_line(9'd42);
		run_line(9'd43);
		run_line(9'd58);
		run_line(9'd59);

		// Three overlapping sprites
		clear_sprites();
		set_sprite(5, 1'b1, 2'd1, 2'd0, 6'd3, 9'd120, 9'd100);
		set_sprite(6, 1'b1, 2'd2, 2'd0, 6'd9, 9'd136, 9'd100);
		set_sprite(7, 1'b1, 2'd3, 2'd1, 6'd20, 9'd140, 9'd98);
		run_line(9'd67);
		run_line(9'd80);

		// Random sets placed around the active line
		for (n = 0; n < 6; n++)
		begin
			v = 9'(random_bits(8));
			ay = (v == 9'd255) ? 32 : int'(v) + 33;
			for (i = 0; i < sprite_count; i++)
				set_sprite(i, random_bits(3) != 0, 2'(random_bits(2)), 2'(random_bits(2)),
					6'(random_bits(6)), 9'(random_bits(9) % 301), 9'(ay - random_bits(5)));
			run_line(v);
		end

		run_line(9'd0);

		$display("Pixels checked %0d, mismatches %0d", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	initial
	begin
		#(watchdog_time);
		$display("Timeout: the run did not end within %0d line periods", line_total);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* hw/sprite_engine.sv */
`default_nettype none

module sprite_engine (
	input logic clk,
	input logic reset,
	input logic hsync,
	input logic [sprite_pkg::pos_w-1:0] vcnt,
	input logic [sprite_pkg::pos_w-1:0] hcnt,
	output logic [sprite_pkg::spr_ram_addr_w-1:0] spr_ram_addr,
	input logic [7:0] spr_ram_data,
	output logic [sprite_pkg::rom_addr_w-1:0] rom_addr,
	input logic [7:0] rom_data,
	output logic [sprite_pkg::pal_addr_w-1:0] pal_addr,
	input logic [sprite_pkg::pal_word_w-1:0] pal_data,
	output logic [7:0] spr_r,
	output logic [7:0] spr_g,
	output logic [7:0] spr_b,
	output logic spr_a
);
	import sprite_pkg::*;

	logic line_start;
	logic busy;
	logic draw_req;
	logic [pos_w-1:0] draw_x;
	logic [9:0] draw_row;
	logic [5:0] draw_image;
	logic [1:0] draw_palette;
	logic [1:0] draw_size;
	logic lb_wr;
	logic [pos_w-1:0] lb_wr_addr;
	logic [pal_word_w-1:0] lb_wr_data;

	sprite_scanner u_scanner (
		.clk(clk),
		.reset(reset),
		.line_start(line_start),
		.vcnt(vcnt),
		.spr_ram_addr(spr_ram_addr),
		.spr_ram_data(spr_ram_data),
		.busy(busy),
		.draw_req(draw_req),
		.draw_x(draw_x),
		.draw_row(draw_row),
		.draw_image(draw_image),
		.draw_palette(draw_palette),
		.draw_size(draw_size)
	);

	sprite_pixel_writer u_writer (
		.clk(clk),
		.reset(reset),
		.line_start(line_start),
		.draw_req(draw_req),
		.draw_x(draw_x),
		.draw_row(draw_row),
		.draw_image(draw_image),
		.draw_palette(draw_palette),
		.draw_size(draw_size),
		.busy(busy),
		.rom_addr(rom_addr),
		.rom_data(rom_data),
		.pal_addr(pal_addr),
		.pal_data(pal_data),
		.lb_wr(lb_wr),
		.lb_wr_addr(lb_wr_addr),
		.lb_wr_data(lb_wr_data)
	);

	sprite_line_buffer u_line_buffer (
		.clk(clk),
		.reset(reset),
		.hsync(hsync),
		.hcnt(hcnt),
		.lb_wr(lb_wr),
		.lb_wr_addr(lb_wr_addr),
		.lb_wr_data(lb_wr_data),
		.line_start(line_start),
		.spr_r(spr_r),
		.spr_g(spr_g),
		.spr_b(spr_b),
		.spr_a(spr_a)
	);

endmodule

`default_nettype wire

/* hw/sprite_line_buffer.sv */
`default_nettype none

module sprite_line_buffer (
	input logic clk,
	input logic reset,
	input logic hsync,
	input logic [sprite_pkg::pos_w-1:0] hcnt,
	input logic lb_wr,
	input logic [sprite_pkg::pos_w-1:0] lb_wr_addr,
	input logic [sprite_pkg::pal_word_w-1:0] lb_wr_data,
	output logic line_start,
	output logic [7:0] spr_r,
	output logic [7:0] spr_g,
	output logic [7:0] spr_b,
	output logic spr_a
);
	import sprite_pkg::*;

	// Two slots of 512 words, the slot bit is the top address bit
	logic [pal_word_w-1:0] mem [0:1023];
	logic [pal_word_w-1:0] rd_data;
	logic hsync_last;
	logic wr_slot;
	logic [pos_w-1:0] rd_addr;

	assign line_start = hsync && !hsync_last;
	assign rd_addr = hcnt + border;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			hsync_last <= 1'b0;
			wr_slot <= 1'b0;
		end
		else
		begin
			hsync_last <= hsync;
			// Swap read and write slots on each new line
			if (line_start)
				wr_slot <= ~wr_slot;
		end
	end

	always_ff @(posedge clk)
	begin
		if (lb_wr)
			mem[{wr_slot, lb_wr_addr}] <= lb_wr_data;
		rd_data <= mem[{~wr_slot, rd_addr}];
	end

	// Widen 5-bit channels by repeating the top bits
	assign spr_r = {rd_data[4:0], rd_data[4:2]};
	assign spr_g = {rd_data[9:5], rd_data[9:7]};
	assign spr_b = {rd_data[14:10], rd_data[14:12]};
	assign spr_a = rd_data[15];

endmodule

`default_nettype wire

/* hw/sprite_pixel_writer.sv */
`default_nettype none

module sprite_pixel_writer (
	input logic clk,
	input logic reset,
	input logic line_start,
	input logic draw_req,
	input logic [sprite_pkg::pos_w-1:0] draw_x,
	input logic [9:0] draw_row,
	input logic [5:0] draw_image,
	input logic [1:0] draw_palette,
	input logic [1:0] draw_size,
	output logic busy,
	output logic [sprite_pkg::rom_addr_w-1:0] rom_addr,
	input logic [7:0] rom_data,
	output logic [sprite_pkg::pal_addr_w-1:0] pal_addr,
	input logic [sprite_pkg::pal_word_w-1:0] pal_data,
	output logic lb_wr,
	output logic [sprite_pkg::pos_w-1:0] lb_wr_addr,
	output logic [sprite_pkg::pal_word_w-1:0] lb_wr_data
);
	import sprite_pkg::*;

	logic [2:0] state;
	logic [2:0] state_next;
	logic [2:0] load_idx;
	logic [pos_w-1:0] pixel;
	logic [pos_w-1:0] span;

	// Image region offsets, indexed by size code
	logic [rom_addr_w-1:0] rom_offset [0:2];

	assign span = size_span(draw_size);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= pw_wait;
			state_next <= pw_load;
			load_idx <= '0;
			rom_addr <= '0;
			busy <= 1'b1;
			lb_wr <= 1'b0;
		end
		else
		begin
			case (state)
				// High byte then low byte for each of the three sizes
				pw_load:
				begin
					if (!load_idx[0])
						rom_offset[load_idx[2:1]][rom_addr_w-1:8] <= rom_data[rom_addr_w-9:0];
					else
						rom_offset[load_idx[2:1]][7:0] <= rom_data;
					rom_addr <= rom_addr + 1'b1;
					load_idx <= load_idx + 1'b1;
					if (load_idx == 3'd5)
					begin
						busy <= 1'b0;
						state <= pw_idle;
					end
					else
					begin
						state <= pw_wait;
						state_next <= pw_load;
					end
				end

				pw_idle:
				begin
					if (line_start)
					begin
						busy <= 1'b1;
						lb_wr <= 1'b1;
						lb_wr_addr <= '0;
						lb_wr_data <= '0;
						state <= pw_clear;
					end
					else if (draw_req)
					begin
						busy <= 1'b1;
						pixel <= '0;
						// Row start of the sprite image in ROM
						case (draw_size)
							size_32: rom_addr <= rom_offset[size_32]
								+ rom_addr_w'({draw_image[3:0], 10'b0})
								+ rom_addr_w'({draw_row, 5'b0});
							size_16: rom_addr <= rom_offset[size_16]
								+ rom_addr_w'({draw_image, 8'b0})
								+ rom_addr_w'({draw_row, 4'b0});
							default: rom_addr <= rom_offset[size_8]
								+ rom_addr_w'({draw_image, 6'b0})
								+ rom_addr_w'({draw_row, 3'b0});
						endcase
						state <= pw_wait;
						state_next <= pw_fetch;
					end
				end

				pw_clear:
				begin
					if (lb_wr_addr < line_max)
						lb_wr_addr <= lb_wr_addr + 1'b1;
					else
					begin
						lb_wr <= 1'b0;
						busy <= 1'b0;
						state <= pw_idle;
					end
				end

				pw_wait:
					state <= state_next;

				pw_fetch:
				begin
					lb_wr <= 1'b0;
					if (pixel > span)
					begin
						busy <= 1'b0;
						state <= pw_idle;
					end
					else
					begin
						pal_addr <= {draw_palette, rom_data[4:0], 1'b0};
						rom_addr <= rom_addr + 1'b1;
						state <= pw_wait;
						state_next <= pw_stage;
					end
				end

				// Alpha clear means transparent, nothing is written
				pw_stage:
				begin
					lb_wr <= pal_data[15];
					lb_wr_addr <= draw_x + pixel;
					lb_wr_data <= pal_data;
					pixel <= pixel + 1'b1;
					state <= pw_fetch;
				end

				default:
					state <= pw_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/sprite_pkg.sv */
`default_nettype none

package sprite_pkg;

	// Widths of positions and memory buses
	localparam int pos_w = 9;
	localparam int rom_addr_w = 14;
	localparam int spr_ram_addr_w = 7;
	localparam int pal_addr_w = 8;
	localparam int pal_word_w = 16;

	// Sprite table layout
	localparam int sprite_count = 32;
	localparam int sprite_index_w = 5;
	localparam int desc_bytes = 4;

	// Screen geometry
	localparam logic [pos_w-1:0] line_max = pos_w'(352);
	localparam logic [pos_w-1:0] border = pos_w'(32);

	// Size codes, also the slots of the ROM offset table
	localparam logic [1:0] size_32 = 2'd0;
	localparam logic [1:0] size_16 = 2'd1;
	localparam logic [1:0] size_8 = 2'd2;

	localparam logic [pos_w-1:0] span_32 = pos_w'(31);
	localparam logic [pos_w-1:0] span_16 = pos_w'(15);
	localparam logic [pos_w-1:0] span_8 = pos_w'(7);

	// Scanner FSM
	localparam logic [3:0] sc_idle = 4'd0;
	localparam logic [3:0] sc_wait_clear = 4'd1;
	localparam logic [3:0] sc_setup_y = 4'd2;
	localparam logic [3:0] sc_wait = 4'd3;
	localparam logic [3:0] sc_read_y0 = 4'd4;
	localparam logic [3:0] sc_read_y1 = 4'd5;
	localparam logic [3:0] sc_check_y = 4'd6;
	localparam logic [3:0] sc_read_x0 = 4'd7;
	localparam logic [3:0] sc_read_x1 = 4'd8;
	localparam logic [3:0] sc_issue = 4'd9;

	// Pixel writer FSM
	localparam logic [2:0] pw_load = 3'd0;
	localparam logic [2:0] pw_idle = 3'd1;
	localparam logic [2:0] pw_clear = 3'd2;
	localparam logic [2:0] pw_wait = 3'd3;
	localparam logic [2:0] pw_fetch = 3'd4;
	localparam logic [2:0] pw_stage = 3'd5;

	// Descriptor bytes 0 and 2 share the sprite RAM data bus
	typedef union packed {
		struct packed {
			logic enable;
			logic reserved;
			logic [1:0] palette;
			logic [1:0] size;
			logic unused;
			logic y_hi;
		} y_view;
		struct packed {
			logic [5:0] image;
			logic unused;
			logic x_hi;
		} x_view;
	} sprite_ctrl_u;

	// Last pixel index of a sprite, code 3 draws a single pixel
	function automatic logic [pos_w-1:0] size_span(input logic [1:0] code);
		case (code)
			size_32: size_span = span_32;
			size_16: size_span = span_16;
			size_8: size_span = span_8;
			default: size_span = '0;
		endcase
	endfunction

endpackage

`default_nettype wire

/* hw/sprite_scanner.sv */
`default_nettype none

module sprite_scanner (
	input logic clk,
	input logic reset,
	input logic line_start,
	input logic [sprite_pkg::pos_w-1:0] vcnt,
	output logic [sprite_pkg::spr_ram_addr_w-1:0] spr_ram_addr,
	input logic [7:0] spr_ram_data,
	input logic busy,
	output logic draw_req,
	output logic [sprite_pkg::pos_w-1:0] draw_x,
	output logic [9:0] draw_row,
	output logic [5:0] draw_image,
	output logic [1:0] draw_palette,
	output logic [1:0] draw_size
);
	import sprite_pkg::*;

	logic [3:0] state;
	logic [3:0] state_next;
	logic [sprite_index_w-1:0] spr_index;
	logic [pos_w-1:0] active_y;
	sprite_ctrl_u ram_byte;

	// Current descriptor
	logic spr_enable;
	logic [1:0] spr_palette;
	logic [1:0] spr_size;
	logic [5:0] spr_image;
	logic [pos_w-1:0] spr_y;
	logic [pos_w-1:0] spr_x;

	logic [pos_w:0] y_end;
	logic visible;
	logic last_sprite;

	assign ram_byte = spr_ram_data;

	// Bottom row of the sprite, one bit wider so it cannot wrap
	assign y_end = {1'b0, spr_y} + {1'b0, size_span(spr_size)};
	assign visible = spr_enable && (active_y >= spr_y) && ({1'b0, active_y} <= y_end);
	assign last_sprite = spr_index == sprite_index_w'(sprite_count - 1);

	always_ff @(posedge clk)
	begin
		draw_req <= 1'b0;
		if (reset)
		begin
			state <= sc_idle;
			state_next <= sc_idle;
			spr_index <= '0;
		end
		else
		begin
			case (state)
				sc_idle:
				begin
					if (line_start && !busy)
					begin
						active_y <= (vcnt == pos_w'(255)) ? border : vcnt + border + pos_w'(1);
						state <= sc_wait_clear;
					end
				end

				// Writer clears the line first
				sc_wait_clear:
				begin
					if (!busy)
					begin
						spr_index <= '0;
						state <= sc_setup_y;
					end
				end

				sc_setup_y:
				begin
					spr_ram_addr <= spr_ram_addr_w'(spr_index * desc_bytes);
					state <= sc_wait;
					state_next <= sc_read_y0;
				end

				sc_wait:
					state <= state_next;

				sc_read_y0:
				begin
					spr_enable <= ram_byte.y_view.enable;
					spr_palette <= ram_byte.y_view.palette;
					spr_size <= ram_byte.y_view.size;
					spr_y[pos_w-1] <= ram_byte.y_view.y_hi;
					spr_ram_addr <= spr_ram_addr + 1'b1;
					state <= sc_wait;
					state_next <= sc_read_y1;
				end

				sc_read_y1:
				begin
					spr_y[7:0] <= spr_ram_data;
					spr_ram_addr <= spr_ram_addr + 1'b1;
					state <= sc_check_y;
				end

				// Also covers the read latency of byte 2
				sc_check_y:
				begin
					if (visible)
						state <= sc_read_x0;
					else if (last_sprite)
						state <= sc_idle;
					else
					begin
						spr_index <= spr_index + 1'b1;
						state <= sc_setup_y;
					end
				end

				sc_read_x0:
				begin
					spr_image <= ram_byte.x_view.image;
					spr_x[pos_w-1] <= ram_byte.x_view.x_hi;
					spr_ram_addr <= spr_ram_addr + 1'b1;
					state <= sc_wait;
					state_next <= sc_read_x1;
				end

				sc_read_x1:
				begin
					spr_x[7:0] <= spr_ram_data;
					state <= sc_issue;
				end

				// Hand over only once the previous sprite is finished
				sc_issue:
				begin
					if (!busy)
					begin
						draw_req <= 1'b1;
						draw_x <= spr_x;
						draw_row <= 10'(active_y - spr_y);
						draw_image <= spr_image;
						draw_palette <= spr_palette;
						draw_size <= spr_size;
						if (last_sprite)
							state <= sc_idle;
						else
						begin
							spr_index <= spr_index + 1'b1;
							state <= sc_setup_y;
						end
					end
				end

				default:
					state <= sc_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* sprite_engine.f */
hw/sprite_pkg.sv
hw/sprite_line_buffer.sv
hw/sprite_scanner.sv
hw/sprite_pixel_writer.sv
hw/sprite_engine.sv
bench/sprite_engine_tb.sv
